/* rtl/fight_pkg.sv */
package fight_pkg;

    //////////////////////////////////////////////////////////////////////
    // fighter values
    //////////////////////////////////////////////////////////////////////

    localparam int stat_w = 8;

    // hp, speed and damage all share this width
    typedef logic [stat_w-1:0] stat_t;

    // battle states, codes match the fight_state output
    typedef enum logic [3:0] {
        fs_menu      = 4'd1,
        fs_skill     = 4'd2,
        fs_strike_p1 = 4'd3,
        fs_strike_p2 = 4'd4,
        fs_drain_p1  = 4'd5,
        fs_drain_p2  = 4'd6,
        fs_p1_win    = 4'd7,
        fs_p2_win    = 4'd8
    } fight_state_t;

    // cursor, 0..3 stands for options 1..4
    typedef logic [1:0] option_t;

    localparam option_t opt_1 = 2'd0;
    localparam option_t opt_2 = 2'd1;
    localparam option_t opt_3 = 2'd2;
    localparam option_t opt_4 = 2'd3;

    // key vector order is U, D, L, R, C
    typedef logic [4:0] key_t;

    localparam key_t press_u = 5'b10000;
    localparam key_t press_d = 5'b01000;
    localparam key_t press_l = 5'b00100;
    localparam key_t press_r = 5'b00010;
    localparam key_t press_c = 5'b00001;

    //////////////////////////////////////////////////////////////////////
    // timer lengths in clock cycles
    //////////////////////////////////////////////////////////////////////

    localparam int anim_cycles    = 16;
    localparam int hp_tick_cycles = 4;
    localparam int ending_cycles  = 32;

    // real skills, option 4 is "back"
    localparam int skill_count = 3;

endpackage

/* rtl/phase_timer.sv */
`timescale 1ns/1ps

module phase_timer #(
    parameter int length = 16
) (
    input  logic clk,
    input  logic reset,
    input  logic start,
    output logic done
);

    localparam int cnt_w = (length > 1) ? $clog2(length) : 1;

    logic [cnt_w-1:0] count;

    // done on the last cycle of each period while running
    assign done = start && (count == cnt_w'(length - 1));

    always_ff @(posedge clk) begin
        if (reset) begin
            count <= '0;
        end else if (!start || done) begin
            // idle or wrapping around for the next period
            count <= '0;
        end else begin
            count <= count + 1'b1;
        end
    end

endmodule

/* rtl/menu_decode.sv */
`timescale 1ns/1ps

module menu_decode (
    input  logic                    clk,
    input  logic                    reset,
    input  fight_pkg::key_t         keys,
    input  fight_pkg::fight_state_t state,
    output fight_pkg::option_t      option,
    output logic                    confirm
);

    import fight_pkg::*;

    logic    key_valid;
    logic    in_menu;
    logic    up;
    logic    down;
    logic    left;
    logic    right;
    logic    select;
    option_t next_option;

    //////////////////////////////////////////////////////////////////////
    // key validation
    //////////////////////////////////////////////////////////////////////

    // two keys at once count as no press
    assign key_valid = $onehot(keys);
    assign {up, down, left, right, select} = key_valid ? keys : '0;

    assign in_menu = (state == fs_menu) || (state == fs_skill);
    assign confirm = in_menu && select;

    //////////////////////////////////////////////////////////////////////
    // cursor navigation
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        next_option = option;
        case (state)
            fs_menu: begin
                // fight | run on one row
                if (right && option == opt_1) begin
                    next_option = opt_2;
                end else if (left && option == opt_2) begin
                    next_option = opt_1;
                end
            end
            fs_skill: begin
                // 1 2 on top, 3 4 below
                case (option)
                    opt_1: begin
                        if (right) next_option = opt_2;
                        else if (down) next_option = opt_3;
                    end
                    opt_2: begin
                        if (left) next_option = opt_1;
                        else if (down) next_option = opt_4;
                    end
                    opt_3: begin
                        if (up) next_option = opt_1;
                        else if (right) next_option = opt_4;
                    end
                    default: begin
                        if (up) next_option = opt_2;
                        else if (left) next_option = opt_3;
                    end
                endcase
            end
            default: begin
                // keys ignored outside the menus
                next_option = opt_1;
            end
        endcase

        // every confirm leaves the current menu
        if (confirm) begin
            next_option = opt_1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            option <= opt_1;
        end else begin
            option <= next_option;
        end
    end

endmodule

/* rtl/hp_meter.sv */
`timescale 1ns/1ps

module hp_meter (
    input  logic             clk,
    input  logic             reset,
    input  fight_pkg::stat_t hp_init,
    input  logic             strike,
    input  fight_pkg::stat_t damage,
    input  logic             drain,
    output fight_pkg::stat_t hp,
    output logic             settled,
    output logic             drained
);

    import fight_pkg::*;

    stat_t target;
    logic  tick_start;
    logic  tick;

    assign settled = (hp == target);
    assign drained = (hp == '0);

    // tick only runs while there is still hp to take off
    assign tick_start = drain && !settled;

    phase_timer #(.length(hp_tick_cycles)) tick_timer (
        .clk   (clk),
        .reset (reset),
        .start (tick_start),
        .done  (tick)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            hp     <= hp_init;
            target <= hp_init;
        end else begin
            if (strike) begin
                // saturate at zero
                target <= (hp > damage) ? stat_t'(hp - damage) : '0;
            end
            if (tick) begin
                hp <= hp - 1'b1;
            end
        end
    end

endmodule

/* rtl/battle_sequencer.sv */
`timescale 1ns/1ps

module battle_sequencer (
    input  logic                    clk,
    input  logic                    reset,
    input  fight_pkg::option_t      option,
    input  logic                    confirm,
    input  fight_pkg::stat_t        p1_speed,
    input  fight_pkg::stat_t        p2_speed,
    input  fight_pkg::stat_t        p1_dmg1,
    input  fight_pkg::stat_t        p1_dmg2,
    input  fight_pkg::stat_t        p1_dmg3,
    input  fight_pkg::stat_t        p2_dmg1,
    input  fight_pkg::stat_t        p2_dmg2,
    input  fight_pkg::stat_t        p2_dmg3,
    input  logic                    p1_settled,
    input  logic                    p1_drained,
    input  logic                    p2_settled,
    input  logic                    p2_drained,
    output fight_pkg::fight_state_t state,
    output logic                    p1_strike,
    output logic                    p2_strike,
    output fight_pkg::stat_t        p1_damage,
    output fight_pkg::stat_t        p2_damage,
    output logic                    p1_drain,
    output logic                    p2_drain,
    output fight_pkg::option_t      p1_skill,
    output fight_pkg::option_t      p2_skill,
    output logic                    fight_over
);

    import fight_pkg::*;

    fight_state_t next_state;
    logic         skill_go;
    logic         p1_first;
    logic         strike_q;
    option_t      pick;
    logic         anim_start;
    logic         anim_done;
    logic         end_start;
    logic         end_done;

    function automatic stat_t skill_damage(
        input option_t skill,
        input stat_t   d1,
        input stat_t   d2,
        input stat_t   d3
    );
        case (skill)
            opt_1:   skill_damage = d1;
            opt_2:   skill_damage = d2;
            default: skill_damage = d3;
        endcase
    endfunction

    // skill confirmed, "back" excluded
    assign skill_go = confirm && (state == fs_skill) && (option != opt_4);

    //////////////////////////////////////////////////////////////////////
    // battle FSM
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        next_state = state;
        case (state)
            fs_menu: begin
                if (confirm) begin
                    next_state = (option == opt_1) ? fs_skill : fs_p2_win;
                end
            end
            fs_skill: begin
                if (confirm && option == opt_4) begin
                    next_state = fs_menu;
                end else if (skill_go) begin
                    // tie goes to player 1
                    next_state = (p1_speed >= p2_speed) ? fs_strike_p1 : fs_strike_p2;
                end
            end
            fs_strike_p1: if (anim_done) next_state = fs_drain_p2;
            fs_strike_p2: if (anim_done) next_state = fs_drain_p1;
            fs_drain_p1: begin
                if (p1_drained) next_state = fs_p2_win;
                else if (p1_settled) next_state = p1_first ? fs_menu : fs_strike_p1;
            end
            fs_drain_p2: begin
                if (p2_drained) next_state = fs_p1_win;
                else if (p2_settled) next_state = p1_first ? fs_strike_p2 : fs_menu;
            end
            default: begin
                // win states hold until reset
                next_state = state;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= fs_menu;
        end else begin
            state <= next_state;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // skills and damage
    //////////////////////////////////////////////////////////////////////

    // opponent move, cycles through the real skills every clock
    always_ff @(posedge clk) begin
        if (reset) begin
            pick <= opt_1;
        end else if (pick == option_t'(skill_count - 1)) begin
            pick <= opt_1;
        end else begin
            pick <= pick + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            p1_skill <= opt_1;
            p2_skill <= opt_1;
            p1_first <= 1'b1;
            strike_q <= 1'b0;
        end else begin
            strike_q <= skill_go;
            if (skill_go) begin
                p1_skill <= option;
                p2_skill <= pick;
                p1_first <= (p1_speed >= p2_speed);
            end
        end
    end

    // both targets load together, the cycle after the confirm
    assign p1_strike = strike_q;
    assign p2_strike = strike_q;

    // damage taken by each fighter, from the opponent's skill
    assign p1_damage = skill_damage(p2_skill, p2_dmg1, p2_dmg2, p2_dmg3);
    assign p2_damage = skill_damage(p1_skill, p1_dmg1, p1_dmg2, p1_dmg3);

    assign p1_drain = (state == fs_drain_p1);
    assign p2_drain = (state == fs_drain_p2);

    //////////////////////////////////////////////////////////////////////
    // timers
    //////////////////////////////////////////////////////////////////////

    assign anim_start = (state == fs_strike_p1) || (state == fs_strike_p2);
    assign end_start  = ((state == fs_p1_win) || (state == fs_p2_win)) && !fight_over;

    phase_timer #(.length(anim_cycles)) anim_timer (
        .clk   (clk),
        .reset (reset),
        .start (anim_start),
        .done  (anim_done)
    );

    phase_timer #(.length(ending_cycles)) end_timer (
        .clk   (clk),
        .reset (reset),
        .start (end_start),
        .done  (end_done)
    );

    // sticky until reset
    always_ff @(posedge clk) begin
        if (reset) begin
            fight_over <= 1'b0;
        end else if (end_done) begin
            fight_over <= 1'b1;
        end
    end

endmodule

/* rtl/fight_top.sv */
`timescale 1ns/1ps

module fight_top (
    input  logic             clk,
    input  logic             reset,
    input  fight_pkg::key_t  keys,
    input  fight_pkg::stat_t p1_hp_init,
    input  fight_pkg::stat_t p1_speed,
    input  fight_pkg::stat_t p1_dmg1,
    input  fight_pkg::stat_t p1_dmg2,
    input  fight_pkg::stat_t p1_dmg3,
    input  fight_pkg::stat_t p2_hp_init,
    input  fight_pkg::stat_t p2_speed,
    input  fight_pkg::stat_t p2_dmg1,
    input  fight_pkg::stat_t p2_dmg2,
    input  fight_pkg::stat_t p2_dmg3,
    output fight_pkg::stat_t p1_hp,
    output fight_pkg::stat_t p2_hp,
    output logic [3:0]       fight_state,
    output logic [2:0]       option_state,
    output logic [2:0]       p1_skill_id,
    output logic [2:0]       p2_skill_id,
    output logic             fight_over
);

    import fight_pkg::*;

    fight_state_t state;
    option_t      option;
    option_t      p1_skill;
    option_t      p2_skill;
    logic         confirm;
    logic         p1_strike;
    logic         p2_strike;
    stat_t        p1_damage;
    stat_t        p2_damage;
    logic         p1_drain;
    logic         p2_drain;
    logic         p1_settled;
    logic         p2_settled;
    logic         p1_drained;
    logic         p2_drained;

    menu_decode menu_decode0 (
        .clk     (clk),
        .reset   (reset),
        .keys    (keys),
        .state   (state),
        .option  (option),
        .confirm (confirm)
    );

    battle_sequencer sequencer0 (
        .clk        (clk),
        .reset      (reset),
        .option     (option),
        .confirm    (confirm),
        .p1_speed   (p1_speed),
        .p2_speed   (p2_speed),
        .p1_dmg1    (p1_dmg1),
        .p1_dmg2    (p1_dmg2),
        .p1_dmg3    (p1_dmg3),
        .p2_dmg1    (p2_dmg1),
        .p2_dmg2    (p2_dmg2),
        .p2_dmg3    (p2_dmg3),
        .p1_settled (p1_settled),
        .p1_drained (p1_drained),
        .p2_settled (p2_settled),
        .p2_drained (p2_drained),
        .state      (state),
        .p1_strike  (p1_strike),
        .p2_strike  (p2_strike),
        .p1_damage  (p1_damage),
        .p2_damage  (p2_damage),
        .p1_drain   (p1_drain),
        .p2_drain   (p2_drain),
        .p1_skill   (p1_skill),
        .p2_skill   (p2_skill),
        .fight_over (fight_over)
    );

    hp_meter hp_p1 (
        .clk     (clk),
        .reset   (reset),
        .hp_init (p1_hp_init),
        .strike  (p1_strike),
        .damage  (p1_damage),
        .drain   (p1_drain),
        .hp      (p1_hp),
        .settled (p1_settled),
        .drained (p1_drained)
    );

    hp_meter hp_p2 (
        .clk     (clk),
        .reset   (reset),
        .hp_init (p2_hp_init),
        .strike  (p2_strike),
        .damage  (p2_damage),
        .drain   (p2_drain),
        .hp      (p2_hp),
        .settled (p2_settled),
        .drained (p2_drained)
    );

    // shown 1-based on the outputs
    assign fight_state  = state;
    assign option_state = {1'b0, option} + 3'd1;
    assign p1_skill_id  = {1'b0, p1_skill} + 3'd1;
    assign p2_skill_id  = {1'b0, p2_skill} + 3'd1;

endmodule

/* tb/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock (
    output logic clk
);

    // 8 ns period
    localparam realtime half_period = 4ns;

    initial begin
        clk = 1'b0;
        forever #(half_period) clk = ~clk;
    end

endmodule

/* tb/fight_tb.sv */
`timescale 1ns/1ps

module fight_tb;

    import fight_pkg::*;

    logic       clk;
    logic       reset;
    logic [4:0] keys;
    stat_t      p1_hp_init;
    stat_t      p1_speed;
    stat_t      p1_dmg1;
    stat_t      p1_dmg2;
    stat_t      p1_dmg3;
    stat_t      p2_hp_init;
    stat_t      p2_speed;
    stat_t      p2_dmg1;
    stat_t      p2_dmg2;
    stat_t      p2_dmg3;
    stat_t      p1_hp;
    stat_t      p2_hp;
    logic [3:0] fight_state;
    logic [2:0] option_state;
    logic [2:0] p1_skill_id;
    logic [2:0] p2_skill_id;
    logic       fight_over;

    // parsed stimulus, each command code followed by its arguments
    int    words[$];
    int    errors;
    int    checks;
    int    cycles;
    int    cycle_limit;
    bit    loaded;
    // model of the fight
    stat_t m_hp1;
    stat_t m_hp2;
    stat_t p1_table[1:3];
    stat_t p2_table[1:3];
    int    m_skill1;
    int    m_skill2;
    bit    pending;
    bit    first_p1;
    // menu position expected by the stimulus
    logic [3:0] exp_state;
    logic [2:0] exp_option;

    tb_clock clock0 (.clk(clk));

    fight_top dut0 (
        .clk          (clk),
        .reset        (reset),
        .keys         (keys),
        .p1_hp_init   (p1_hp_init),
        .p1_speed     (p1_speed),
        .p1_dmg1      (p1_dmg1),
        .p1_dmg2      (p1_dmg2),
        .p1_dmg3      (p1_dmg3),
        .p2_hp_init   (p2_hp_init),
        .p2_speed     (p2_speed),
        .p2_dmg1      (p2_dmg1),
        .p2_dmg2      (p2_dmg2),
        .p2_dmg3      (p2_dmg3),
        .p1_hp        (p1_hp),
        .p2_hp        (p2_hp),
        .fight_state  (fight_state),
        .option_state (option_state),
        .p1_skill_id  (p1_skill_id),
        .p2_skill_id  (p2_skill_id),
        .fight_over   (fight_over)
    );

    //////////////////////////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////////////////////////

    task automatic state_is(input logic [3:0] want);
        checks++;
        if (fight_state != want) begin
            $display("error fight_state: expected %h, got %h", want, fight_state);
            errors++;
        end
    endtask

    task automatic id_is(input string name, input logic [2:0] got, input logic [2:0] want);
        checks++;
        if (got != want) begin
            $display("error %s: expected %h, got %h", name, want, got);
            errors++;
        end
    endtask

    task automatic hp_is(input string name, input stat_t got, input stat_t want);
        checks++;
        if (got != want) begin
            $display("error %s: expected %h, got %h", name, want, got);
            errors++;
        end
    endtask

    task automatic flag_is(input string name, input logic got, input logic want);
        checks++;
        if (got != want) begin
            $display("error %s: expected %h, got %h", name, want, got);
            errors++;
        end
    endtask

    // hp after a hit, never below zero
    function automatic stat_t after_hit(input stat_t hp, input stat_t dmg);
        int left;
        left = int'(hp) - int'(dmg);
        if (left < 0) begin
            left = 0;
        end
        return stat_t'(left);
    endfunction

    function automatic logic [4:0] key_code(input string letter);
        case (letter)
            "U": return press_u;
            "D": return press_d;
            "L": return press_l;
            "R": return press_r;
            "C": return press_c;
            "X": return press_r | press_c;
            default: return 5'b00000;
        endcase
    endfunction

    //////////////////////////////////////////////////////////////////////
    // stimulus file
    //////////////////////////////////////////////////////////////////////

    task automatic load_commands(output bit ok);
        int    fd;
        int    rc;
        int    a;
        int    b;
        int    v;
        string tok;
        string letter;
        string rest;
        ok = 1'b0;
        fd = $fopen("tb/fight_stim.txt", "r");
        if (fd != 0) begin
            ok = 1'b1;
            rc = $fscanf(fd, "%s", tok);
            while (rc == 1) begin
                if (tok == "S") begin
                    words.push_back(1);
                    for (int i = 0; i < 10; i++) begin
                        rc = $fscanf(fd, "%d", v);
                        words.push_back(v);
                    end
                end else if (tok == "K") begin
                    rc = $fscanf(fd, "%s %d %d", letter, a, b);
                    if (key_code(letter) == 5'b00000) begin
                        $display("unknown key letter in the stimulus file");
                        errors++;
                    end
                    words.push_back(2);
                    words.push_back(int'(key_code(letter)));
                    words.push_back(a);
                    words.push_back(b);
                end else if (tok == "W") begin
                    rc = $fscanf(fd, "%d", a);
                    words.push_back(3);
                    words.push_back(a);
                end else begin
                    // comment line
                    rc = $fgets(rest, fd);
                end
                rc = $fscanf(fd, "%s", tok);
            end
            $fclose(fd);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // scenario steps
    //////////////////////////////////////////////////////////////////////

    task automatic start_scenario();
        @(negedge clk);
        p1_hp_init = stat_t'(words.pop_front());
        p1_speed   = stat_t'(words.pop_front());
        p1_dmg1    = stat_t'(words.pop_front());
        p1_dmg2    = stat_t'(words.pop_front());
        p1_dmg3    = stat_t'(words.pop_front());
        p2_hp_init = stat_t'(words.pop_front());
        p2_speed   = stat_t'(words.pop_front());
        p2_dmg1    = stat_t'(words.pop_front());
        p2_dmg2    = stat_t'(words.pop_front());
        p2_dmg3    = stat_t'(words.pop_front());
        p1_table   = '{p1_dmg1, p1_dmg2, p1_dmg3};
        p2_table   = '{p2_dmg1, p2_dmg2, p2_dmg3};
        keys  = '0;
        reset = 1'b1;
        repeat (3) @(negedge clk);
        reset = 1'b0;
        m_hp1      = p1_hp_init;
        m_hp2      = p2_hp_init;
        pending    = 1'b0;
        exp_state  = 4'd1;
        exp_option = 3'd1;
        state_is(4'd1);
        id_is("option_state", option_state, 3'd1);
        hp_is("p1_hp", p1_hp, p1_hp_init);
        hp_is("p2_hp", p2_hp, p2_hp_init);
        flag_is("fight_over", fight_over, 1'b0);
        id_is("p1_skill_id", p1_skill_id, 3'd1);
        id_is("p2_skill_id", p2_skill_id, 3'd1);
    endtask

    task automatic press_key(input logic [4:0] code, input logic [3:0] want_state,
                             input logic [2:0] want_option);
        int         gap;
        logic [3:0] st_before;
        logic [2:0] opt_before;
        gap = int'($urandom_range(4, 1));
        repeat (gap) @(negedge clk);
        st_before  = exp_state;
        opt_before = exp_option;
        keys = code;
        @(negedge clk);
        keys = '0;
        state_is(want_state);
        id_is("option_state", option_state, want_option);
        exp_state  = want_state;
        exp_option = want_option;
        // a real skill confirmed in the skill menu
        if (st_before == 4'd2 && code == press_c && opt_before != 3'd4) begin
            pending  = 1'b1;
            first_p1 = (p1_speed >= p2_speed);
            state_is(first_p1 ? 4'd3 : 4'd4);
            id_is("p1_skill_id", p1_skill_id, opt_before);
            checks++;
            if (p2_skill_id < 3'd1 || p2_skill_id > 3'd3) begin
                $display("error p2_skill_id: expected 1..3, got %h", p2_skill_id);
                errors++;
            end
            m_skill1 = int'(opt_before);
            m_skill2 = int'(p2_skill_id);
        end
    endtask

    task automatic finish_turn(input logic [3:0] want_end);
        stat_t      floor1;
        stat_t      floor2;
        stat_t      last1;
        stat_t      last2;
        stat_t      want1;
        stat_t      want2;
        logic [3:0] model_end;
        int         waited;
        floor1    = m_hp1;
        floor2    = m_hp2;
        want1     = m_hp1;
        want2     = m_hp2;
        model_end = want_end;
        if (pending) begin
            floor1 = after_hit(m_hp1, p2_table[m_skill2]);
            floor2 = after_hit(m_hp2, p1_table[m_skill1]);
            // the second blow only lands if the first one did not knock out
            if (first_p1) begin
                want2 = floor2;
                want1 = (want2 == 0) ? m_hp1 : floor1;
            end else begin
                want1 = floor1;
                want2 = (want1 == 0) ? m_hp2 : floor2;
            end
            model_end = (want2 == 0) ? 4'd7 : ((want1 == 0) ? 4'd8 : 4'd1);
            if (model_end != want_end) begin
                $display("stimulus outcome does not match the exchange worked out from the stats");
                errors++;
            end
        end
        last1 = p1_hp;
        last2 = p2_hp;
        while (fight_state != 4'd1 && fight_state != 4'd7 && fight_state != 4'd8) begin
            @(negedge clk);
            checks++;
            if (p1_hp > last1 || p1_hp < floor1) begin
                $display("error p1_hp: expected %h..%h, got %h", floor1, last1, p1_hp);
                errors++;
            end
            checks++;
            if (p2_hp > last2 || p2_hp < floor2) begin
                $display("error p2_hp: expected %h..%h, got %h", floor2, last2, p2_hp);
                errors++;
            end
            last1 = p1_hp;
            last2 = p2_hp;
        end
        state_is(want_end);
        hp_is("p1_hp", p1_hp, want1);
        hp_is("p2_hp", p2_hp, want2);
        m_hp1      = want1;
        m_hp2      = want2;
        pending    = 1'b0;
        exp_state  = want_end;
        exp_option = 3'd1;
        if (want_end == 4'd7 || want_end == 4'd8) begin
            flag_is("fight_over", fight_over, 1'b0);
            waited = 0;
            while (!fight_over) begin
                @(negedge clk);
                waited++;
            end
            checks++;
            if (waited != ending_cycles) begin
                $display("error fight_over delay: expected %h, got %h", ending_cycles, waited);
                errors++;
            end
            // win state and flag hold
            repeat (8) begin
                @(negedge clk);
                flag_is("fight_over", fight_over, 1'b1);
                state_is(want_end);
            end
            hp_is("p1_hp", p1_hp, want1);
            hp_is("p2_hp", p2_hp, want2);
        end
    endtask

    task automatic run_commands();
        int kind;
        int code;
        int st;
        int opt;
        while (words.size() > 0) begin
            kind = words.pop_front();
            case (kind)
                1: start_scenario();
                2: begin
                    code = words.pop_front();
                    st   = words.pop_front();
                    opt  = words.pop_front();
                    press_key(5'(code), 4'(st), 3'(opt));
                end
                3: finish_turn(4'(words.pop_front()));
                default: begin
                    $display("unknown command in the parsed stimulus");
                    errors++;
                end
            endcase
        end
    endtask

    // run limit from the number of scenarios and key presses
    function automatic int limit_for_run();
        int scenarios;
        int presses;
        int turn_max;
        int i;
        scenarios = 0;
        presses   = 0;
        i         = 0;
        while (i < words.size()) begin
            if (words[i] == 1) begin
                scenarios++;
                i = i + 11;
            end else if (words[i] == 2) begin
                presses++;
                i = i + 4;
            end else begin
                i = i + 2;
            end
        end
        turn_max = 2 * (anim_cycles + 255 * hp_tick_cycles + 2);
        return presses * 8 + scenarios * (2 * turn_max + 2 * ending_cycles);
    endfunction

    //////////////////////////////////////////////////////////////////////
    // main flow and watchdog
    //////////////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("Simulation failed");
            $finish;
        end
    end

    initial begin
        reset       = 1'b1;
        keys        = '0;
        p1_hp_init  = '0;
        p1_speed    = '0;
        p1_dmg1     = '0;
        p1_dmg2     = '0;
        p1_dmg3     = '0;
        p2_hp_init  = '0;
        p2_speed    = '0;
        p2_dmg1     = '0;
        p2_dmg2     = '0;
        p2_dmg3     = '0;
        errors      = 0;
        checks      = 0;
        cycle_limit = 0;
        void'($urandom(32'h994a_7806));
        load_commands(loaded);
        if (!loaded) begin
            $display("could not open the stimulus file tb/fight_stim.txt");
            $display("Simulation failed");
            $finish;
        end else begin
            cycle_limit = limit_for_run();
            run_commands();
            $display("%0d checks, %0d errors", checks, errors);
            if (errors == 0) begin
                $display("Simulation passed");
            end else begin
                $display("Simulation failed");
            end
            $finish;
        end
    end

endmodule

/* project.f */
rtl/fight_pkg.sv
rtl/phase_timer.sv
rtl/menu_decode.sv
rtl/hp_meter.sv
rtl/battle_sequencer.sv
rtl/fight_top.sv
tb/tb_clock.sv
tb/fight_tb.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing -j 0
TOP      = fight_tb
FILELIST = project.f
BUILD    = obj_dir
PASS_MSG = Simulation passed

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

run: compile
	@out="$$(./$(BUILD)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD)

/* tb/fight_stim.txt */
# S  p1: hp speed dmg1 dmg2 dmg3   p2: hp speed dmg1 dmg2 dmg3   (reset, then new fighters)
# K  key(U D L R C, X = two keys)  state after  option after  /  W  state at end of turn
S 40 9 5 7 11 30 4 3 6 8
K L 1 1
K R 1 2
K R 1 2
K L 1 1
K U 1 1
K C 2 1
K U 2 1
K R 2 2
K D 2 4
K R 2 4
K L 2 3
K D 2 3
K U 2 1
K X 2 1
K D 2 3
K R 2 4
K C 1 1
K C 2 1
K R 2 2
K C 3 1
W 1
K C 2 1
K C 3 1
W 1
# speed tie, player 1 first
S 20 5 2 3 4 20 5 1 1 1
K C 2 1
K D 2 3
K C 3 1
W 1
# faster opponent knocks player 1 out
S 10 3 1 2 3 50 9 12 15 20
K C 2 1
K C 4 1
W 8
# exact knock-out by player 1
S 25 7 6 8 9 6 2 1 2 3
K C 2 1
K C 3 1
W 7
# run away, keys ignored afterwards
S 33 4 1 1 1 44 5 1 1 1
K R 1 2
K C 8 1
W 8
K U 8 1
